/* files.f */
hdl/trap_pkg.sv
hdl/csr_step_timer.sv
hdl/trap_fsm.sv
hdl/csr_write_gen.sv
hdl/csr_file.sv
hdl/trap_unit.sv
bench/trap_unit_tb.sv

/* Bender.yml */
package:
  name: trap_unit

sources:
  # rtl, package first
  - hdl/trap_pkg.sv
  - hdl/csr_step_timer.sv
  - hdl/trap_fsm.sv
  - hdl/csr_write_gen.sv
  - hdl/csr_file.sv
  - hdl/trap_unit.sv

  # simulation only
  - target: test
    files:
      - bench/trap_unit_tb.sv

/* bench/trap_unit_tb.sv */
// testbench for the trap unit
// lfsr stimulus, csr reference model, req/ack compare process and watchdog
`default_nettype none

module trap_unit_tb import trap_pkg::*; ();

  localparam int PERIOD = 100;
  localparam int N_RANDOM = 40;
  localparam int N_OPS = N_RANDOM + 4;
  localparam int MAX_ACK = 7;
  localparam int WATCHDOG_CYCLES = N_OPS * (9 + MAX_ACK + 4) + 2000;

  // modelled csr state plus the redirect target of the last operation
  typedef struct packed {
    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t target;
  } csr_model_t;

  typedef struct packed {
    xlen_t       target;
    logic [31:0] start;
    logic [3:0]  lat;
  } pending_t;

  logic       clk;
  logic       rst;
  logic       i_ena;
  trap_kind_t i_kind;
  xlen_t      i_pc;
  logic       i_ack;
  logic       o_req;
  xlen_t      o_target_pc;
  logic       o_busy;
  logic       i_sw_wen;
  csr_addr_t  i_sw_addr;
  xlen_t      i_sw_wdata;
  csr_addr_t  i_sw_raddr;
  xlen_t      o_sw_rdata;

  logic [31:0] lfsr = 32'h8add;
  int          errors = 0;
  int          checks = 0;
  int          edge_cnt = 0;
  csr_model_t  model;
  pending_t    pend_q[$];
  logic        req_q = 1'b0;
  xlen_t       held_target;

  trap_unit trap_unit_i (
    .clk         (clk),
    .rst         (rst),
    .i_ena       (i_ena),
    .i_kind      (i_kind),
    .i_pc        (i_pc),
    .i_ack       (i_ack),
    .o_req       (o_req),
    .o_target_pc (o_target_pc),
    .o_busy      (o_busy),
    .i_sw_wen    (i_sw_wen),
    .i_sw_addr   (i_sw_addr),
    .i_sw_wdata  (i_sw_wdata),
    .i_sw_raddr  (i_sw_raddr),
    .o_sw_rdata  (o_sw_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // rising edges seen so far, read on falling edges only
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[XLEN-2:0], lfsr[0]};
    end
    return r;
  endfunction

  // expected csr state and target after one trap or mret
  function automatic csr_model_t predict(input trap_kind_t kind, input xlen_t pc,
                                         input csr_model_t cur);
    csr_model_t nxt;
    nxt = cur;
    if (kind == KIND_MRET) begin
      nxt.mstatus[MSTATUS_MIE] = cur.mstatus[MSTATUS_MPIE];
      nxt.mstatus[MSTATUS_MPIE] = 1'b1;
      nxt.target = cur.mepc;
    end else begin
      nxt.mepc = {pc[XLEN-1:1], 1'b0};
      nxt.mcause = (kind == KIND_EBREAK) ? CAUSE_BREAKPOINT : CAUSE_ECALL_M;
      nxt.mstatus[MSTATUS_MPIE] = cur.mstatus[MSTATUS_MIE];
      nxt.mstatus[MSTATUS_MIE] = 1'b0;
      nxt.mstatus[MSTATUS_MPP_LO +: 2] = 2'b11;
      nxt.target = cur.mtvec;
    end
    return nxt;
  endfunction

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h exp 0x%h", name, got, exp);
    end
  endtask

  task automatic sw_write(input csr_addr_t addr, input xlen_t data);
    case (addr)
      CSR_MSTATUS: model.mstatus = data;
      CSR_MTVEC: model.mtvec = {data[XLEN-1:2], 2'b00};
      CSR_MEPC: model.mepc = {data[XLEN-1:1], 1'b0};
      CSR_MCAUSE: model.mcause = data;
      default: ;
    endcase
    @(negedge clk);
    i_sw_wen = 1'b1;
    i_sw_addr = addr;
    i_sw_wdata = data;
    @(negedge clk);
    i_sw_wen = 1'b0;
  endtask

  // read port is combinational, sampled a quarter period after the address
  task automatic sw_read_check(input csr_addr_t addr, input xlen_t exp, input string name);
    @(negedge clk);
    i_sw_raddr = addr;
    #(PERIOD / 4);
    check_xlen(name, o_sw_rdata, exp);
  endtask

  task automatic check_all_csrs();
    sw_read_check(CSR_MSTATUS, model.mstatus, "o_sw_rdata mstatus");
    sw_read_check(CSR_MTVEC, model.mtvec, "o_sw_rdata mtvec");
    sw_read_check(CSR_MEPC, model.mepc, "o_sw_rdata mepc");
    sw_read_check(CSR_MCAUSE, model.mcause, "o_sw_rdata mcause");
  endtask

  // one operation: strobe, wait for o_req, hold off ack, then acknowledge
  task automatic run_op(input trap_kind_t kind, input xlen_t pc, input int ack_delay,
                        input logic stray);
    pending_t p;
    int       waited;
    model = predict(kind, pc, model);
    p.target = model.target;
    p.lat = (kind == KIND_MRET) ? 4'd3 : 4'd9;
    @(negedge clk);
    p.start = edge_cnt;
    pend_q.push_back(p);
    i_ena = 1'b1;
    i_kind = kind;
    i_pc = pc;
    @(negedge clk);
    i_ena = 1'b0;
    waited = 0;
    while (!o_req && waited < 20) begin
      // busy through every csr write state
      check_bit("o_busy", o_busy, 1'b1);
      @(negedge clk);
      waited++;
    end
    if (!o_req) begin
      errors++;
      $display("o_req did not rise within 20 cycles of the strobe");
      return;
    end
    for (int d = 0; d < ack_delay; d++) begin
      check_bit("o_req", o_req, 1'b1);
      // a strobe while busy must be dropped
      i_ena = stray && (d == 0);
      i_kind = KIND_ECALL;
      i_pc = rand_bits(64);
      @(negedge clk);
    end
    check_bit("o_req", o_req, 1'b1);
    i_ena = 1'b0;
    i_ack = 1'b1;
    @(negedge clk);
    i_ack = 1'b0;
    // released on the edge after the ack cycle
    check_bit("o_req", o_req, 1'b0);
    check_bit("o_busy", o_busy, 1'b0);
  endtask

  // checks every o_req rise and the hold while it stays high
  always @(negedge clk) begin
    pending_t p;
    if (o_req && !req_q) begin
      if (pend_q.size() == 0) begin
        errors++;
        $display("o_req rose with no operation pending");
      end else begin
        p = pend_q.pop_front();
        check_xlen("o_target_pc", o_target_pc, p.target);
        check_xlen("o_req latency", xlen_t'(edge_cnt - p.start - 1), xlen_t'(p.lat));
        held_target = o_target_pc;
      end
    end else if (o_req) begin
      check_xlen("o_target_pc held", o_target_pc, held_target);
    end
    if (o_req) begin
      check_bit("o_busy", o_busy, 1'b1);
    end
    req_q = o_req;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    trap_kind_t kind;
    xlen_t      k;
    rst = 1'b1;
    i_ena = 1'b0;
    i_kind = KIND_ECALL;
    i_pc = '0;
    i_ack = 1'b0;
    i_sw_wen = 1'b0;
    i_sw_addr = '0;
    i_sw_wdata = '0;
    i_sw_raddr = '0;
    model = '0;
    model.mstatus[MSTATUS_MPP_LO +: 2] = 2'b11;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("o_req", o_req, 1'b0);
    check_bit("o_busy", o_busy, 1'b0);

    // reset values, unknown address, then masking on all four csrs
    check_all_csrs();
    sw_read_check(12'h7c0, '0, "o_sw_rdata unknown");
    sw_write(CSR_MSTATUS, rand_bits(64));
    sw_write(CSR_MTVEC, rand_bits(64) | 64'h3);
    sw_write(CSR_MEPC, rand_bits(64) | 64'h1);
    sw_write(CSR_MCAUSE, rand_bits(64));
    check_all_csrs();

    // ecall with a fresh mtvec and mie set
    sw_write(CSR_MTVEC, rand_bits(64));
    sw_write(CSR_MSTATUS, 64'h8);
    run_op(KIND_ECALL, rand_bits(64), 0, 1'b0);
    check_all_csrs();

    // ebreak, then mret pops mpie back into mie
    sw_write(CSR_MSTATUS, 64'h8);
    run_op(KIND_EBREAK, rand_bits(64), 0, 1'b0);
    check_all_csrs();
    run_op(KIND_MRET, '0, 0, 1'b0);
    check_all_csrs();

    // back-pressure with a stray strobe
    run_op(KIND_ECALL, rand_bits(64), 3 + int'(rand_bits(2)), 1'b1);
    check_all_csrs();

    for (int i = 0; i < N_RANDOM; i++) begin
      if (rand_bits(3) == 0) begin
        sw_write(CSR_MTVEC, rand_bits(64));
      end
      k = rand_bits(2);
      kind = (k == 3) ? KIND_ECALL : trap_kind_t'(k[1:0]);
      run_op(kind, rand_bits(64), int'(rand_bits(3)), rand_bits(3) == 0);
      check_all_csrs();
    end

    repeat (4) @(negedge clk);
    $display("run done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/trap_unit.sv */
// machine-mode trap unit top
// sequencer fsm, step timer, csr write decode and csr file
`default_nettype none

module trap_unit import trap_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       i_ena,
  input  wire trap_kind_t i_kind,
  input  wire xlen_t      i_pc,
  input  wire logic       i_ack,
  output logic            o_req,
  output xlen_t           o_target_pc,
  output logic            o_busy,
  input  wire logic       i_sw_wen,
  input  wire csr_addr_t  i_sw_addr,
  input  wire xlen_t      i_sw_wdata,
  input  wire csr_addr_t  i_sw_raddr,
  output xlen_t           o_sw_rdata
);

  seq_state_t state;
  trap_kind_t kind;
  xlen_t      pc;
  logic [1:0] step;
  logic       step_done;
  logic       step_run;
  logic       seq_wen;
  csr_addr_t  seq_addr;
  xlen_t      seq_wdata;
  xlen_t      mstatus;
  xlen_t      mtvec;
  xlen_t      mepc;

  // timer paces only the csr write states
  assign step_run = (state != ST_IDLE) && (state != ST_REPORT);

  trap_fsm trap_fsm_i (
    .clk         (clk),
    .rst         (rst),
    .i_ena       (i_ena),
    .i_kind      (i_kind),
    .i_pc        (i_pc),
    .i_step_done (step_done),
    .i_ack       (i_ack),
    .i_mtvec     (mtvec),
    .i_mepc      (mepc),
    .o_state     (state),
    .o_kind      (kind),
    .o_pc        (pc),
    .o_req       (o_req),
    .o_target_pc (o_target_pc),
    .o_busy      (o_busy)
  );

  csr_step_timer csr_step_timer_i (
    .clk         (clk),
    .rst         (rst),
    .i_run       (step_run),
    .o_step      (step),
    .o_step_done (step_done)
  );

  csr_write_gen csr_write_gen_i (
    .i_state   (state),
    .i_step    (step),
    .i_kind    (kind),
    .i_pc      (pc),
    .i_mstatus (mstatus),
    .o_wen     (seq_wen),
    .o_waddr   (seq_addr),
    .o_wdata   (seq_wdata)
  );

  csr_file csr_file_i (
    .clk         (clk),
    .rst         (rst),
    .i_seq_wen   (seq_wen),
    .i_seq_addr  (seq_addr),
    .i_seq_wdata (seq_wdata),
    .i_sw_wen    (i_sw_wen),
    .i_sw_addr   (i_sw_addr),
    .i_sw_wdata  (i_sw_wdata),
    .i_sw_raddr  (i_sw_raddr),
    .o_sw_rdata  (o_sw_rdata),
    .o_mstatus   (mstatus),
    .o_mtvec     (mtvec),
    .o_mepc      (mepc)
  );

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
// machine csr registers mstatus, mtvec, mepc and mcause
// sequencer write port, software write port and software read port
`default_nettype none

module csr_file import trap_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      i_seq_wen,
  input  wire csr_addr_t i_seq_addr,
  input  wire xlen_t     i_seq_wdata,
  input  wire logic      i_sw_wen,
  input  wire csr_addr_t i_sw_addr,
  input  wire xlen_t     i_sw_wdata,
  input  wire csr_addr_t i_sw_raddr,
  output xlen_t          o_sw_rdata,
  output xlen_t          o_mstatus,
  output xlen_t          o_mtvec,
  output xlen_t          o_mepc
);

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mstatus_rst;

  always_comb begin
    mstatus_rst = '0;
    mstatus_rst[MSTATUS_MPP_LO +: 2] = PRIV_M;
  end

  // sequencer wins when both ports hit the same register
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= mstatus_rst;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else begin
      if (i_seq_wen && i_seq_addr == CSR_MSTATUS) begin
        mstatus <= i_seq_wdata;
      end else if (i_sw_wen && i_sw_addr == CSR_MSTATUS) begin
        mstatus <= i_sw_wdata;
      end

      // direct mode only, base is word aligned
      if (i_seq_wen && i_seq_addr == CSR_MTVEC) begin
        mtvec <= {i_seq_wdata[XLEN-1:2], 2'b00};
      end else if (i_sw_wen && i_sw_addr == CSR_MTVEC) begin
        mtvec <= {i_sw_wdata[XLEN-1:2], 2'b00};
      end

      // bit 0 of mepc is hardwired to zero
      if (i_seq_wen && i_seq_addr == CSR_MEPC) begin
        mepc <= {i_seq_wdata[XLEN-1:1], 1'b0};
      end else if (i_sw_wen && i_sw_addr == CSR_MEPC) begin
        mepc <= {i_sw_wdata[XLEN-1:1], 1'b0};
      end

      if (i_seq_wen && i_seq_addr == CSR_MCAUSE) begin
        mcause <= i_seq_wdata;
      end else if (i_sw_wen && i_sw_addr == CSR_MCAUSE) begin
        mcause <= i_sw_wdata;
      end
    end
  end

  always_comb begin
    case (i_sw_raddr)
      CSR_MSTATUS: o_sw_rdata = mstatus;
      CSR_MTVEC: o_sw_rdata = mtvec;
      CSR_MEPC: o_sw_rdata = mepc;
      CSR_MCAUSE: o_sw_rdata = mcause;
      default: o_sw_rdata = '0;
    endcase
  end

  assign o_mstatus = mstatus;
  assign o_mtvec = mtvec;
  assign o_mepc = mepc;

endmodule

`default_nettype wire

/* hdl/csr_write_gen.sv */
// sequencer csr write decode
// address, data and strobe per state, including the mstatus trap fields
`default_nettype none

module csr_write_gen import trap_pkg::*; (
  input  wire seq_state_t i_state,
  input  wire logic [1:0] i_step,
  input  wire trap_kind_t i_kind,
  input  wire xlen_t      i_pc,
  input  wire xlen_t      i_mstatus,
  output logic            o_wen,
  output csr_addr_t       o_waddr,
  output xlen_t           o_wdata
);

  xlen_t trap_mstatus;
  xlen_t mret_mstatus;
  logic  writing;

  // mstatus on trap entry: stack mie into mpie, disable, mpp to machine
  always_comb begin
    trap_mstatus = i_mstatus;
    trap_mstatus[MSTATUS_MPIE] = i_mstatus[MSTATUS_MIE];
    trap_mstatus[MSTATUS_MIE] = 1'b0;
    trap_mstatus[MSTATUS_MPP_LO +: 2] = PRIV_M;
  end

  // mstatus on mret: pop mpie back into mie
  always_comb begin
    mret_mstatus = i_mstatus;
    mret_mstatus[MSTATUS_MIE] = i_mstatus[MSTATUS_MPIE];
    mret_mstatus[MSTATUS_MPIE] = 1'b1;
  end

  always_comb begin
    writing = 1'b1;
    o_waddr = CSR_MEPC;
    o_wdata = i_pc;
    case (i_state)
      ST_MEPC: begin
        o_waddr = CSR_MEPC;
        o_wdata = i_pc;
      end
      ST_MCAUSE: begin
        o_waddr = CSR_MCAUSE;
        o_wdata = (i_kind == KIND_EBREAK) ? CAUSE_BREAKPOINT : CAUSE_ECALL_M;
      end
      ST_MSTATUS: begin
        o_waddr = CSR_MSTATUS;
        o_wdata = trap_mstatus;
      end
      ST_RESTORE: begin
        o_waddr = CSR_MSTATUS;
        o_wdata = mret_mstatus;
      end
      default: writing = 1'b0;
    endcase
  end

  // strobe only in the issue step, released in the two after it
  assign o_wen = writing && (i_step == 2'd0);

endmodule

`default_nettype wire

/* hdl/trap_fsm.sv */
// trap sequencer state machine
// orders the csr writes for a trap or an mret and runs the req/ack handshake
`default_nettype none

module trap_fsm import trap_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       i_ena,
  input  wire trap_kind_t i_kind,
  input  wire xlen_t      i_pc,
  input  wire logic       i_step_done,
  input  wire logic       i_ack,
  input  wire xlen_t      i_mtvec,
  input  wire xlen_t      i_mepc,
  output seq_state_t      o_state,
  output trap_kind_t      o_kind,
  output xlen_t           o_pc,
  output logic            o_req,
  output xlen_t           o_target_pc,
  output logic            o_busy
);

  seq_state_t state;
  seq_state_t state_d;
  logic       accept;
  logic       enter_report;
  logic       hs;

  assign hs = o_req && i_ack;
  assign accept = (state == ST_IDLE) && i_ena;
  assign enter_report = (state_d == ST_REPORT) && (state != ST_REPORT);

  always_comb begin
    state_d = state;
    case (state)
      ST_IDLE: begin
        if (i_ena) begin
          // mret skips the trap writes and only restores mstatus
          state_d = (i_kind == KIND_MRET) ? ST_RESTORE : ST_MEPC;
        end
      end
      ST_MEPC: if (i_step_done) state_d = ST_MCAUSE;
      ST_MCAUSE: if (i_step_done) state_d = ST_MSTATUS;
      ST_MSTATUS: if (i_step_done) state_d = ST_REPORT;
      ST_RESTORE: if (i_step_done) state_d = ST_REPORT;
      ST_REPORT: if (hs) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      o_req <= 1'b0;
    end else begin
      state <= state_d;
      if (enter_report) begin
        o_req <= 1'b1;
      end else if (hs) begin
        o_req <= 1'b0;
      end
    end
  end

  // operation payload, captured when the strobe is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      o_kind <= i_kind;
      o_pc <= i_pc;
    end
  end

  // redirect target is sampled once on the way into report
  always_ff @(posedge clk) begin
    if (enter_report) begin
      o_target_pc <= (state == ST_RESTORE) ? i_mepc : i_mtvec;
    end
  end

  assign o_state = state;
  assign o_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

/* hdl/csr_step_timer.sv */
// step counter that gives each sequencer csr write its three-cycle shape
`default_nettype none

module csr_step_timer import trap_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       i_run,
  output logic      [1:0] o_step,
  output logic            o_step_done
);

  logic [1:0] step;

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= 2'd0;
    end else if (!i_run) begin
      step <= 2'd0;
    end else if (step == STEP_LAST) begin
      // wraps together with the state advance
      step <= 2'd0;
    end else begin
      step <= step + 2'd1;
    end
  end

  assign o_step = step;
  assign o_step_done = i_run && (step == STEP_LAST);

endmodule

`default_nettype wire

/* hdl/trap_pkg.sv */
// shared types and constants for the machine-mode trap sequencer
// csr addresses, cause codes, mstatus bit positions and fsm encodings
`default_nettype none

package trap_pkg;

  localparam int XLEN = 64;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // machine csr addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC = 12'h305;
  localparam csr_addr_t CSR_MEPC = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

  // synchronous exception codes written to mcause
  localparam xlen_t CAUSE_ECALL_M = 64'd11;
  localparam xlen_t CAUSE_BREAKPOINT = 64'd3;

  // trap fields of mstatus
  localparam int MSTATUS_MIE = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam logic [1:0] PRIV_M = 2'b11;

  // one csr write is issue, release, done
  localparam logic [1:0] STEP_LAST = 2'd2;

  typedef enum logic [1:0] {
    KIND_ECALL,
    KIND_EBREAK,
    KIND_MRET
  } trap_kind_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MEPC,
    ST_MCAUSE,
    ST_MSTATUS,
    ST_RESTORE,
    ST_REPORT
  } seq_state_t;

endpackage

`default_nettype wire
